/* source/score_pkg.sv */
package score_pkg;

    // Digit code sent from the controller to the decoder
    typedef logic [3:0] digit_t;

    // Segment pattern, bit 0 is segment a and bit 6 is segment g
    typedef logic [6:0] seg_t;

    // Codes above the decimal digits
    localparam digit_t DIGIT_OFF = 4'd10;   // Both segments dark
    localparam digit_t DIGIT_P   = 4'd11;   // Letter P

    // Highest decimal digit
    localparam digit_t DIGIT_MAX = 4'd9;

    // Default timing at 1 kHz
    localparam int DEF_BLINK_TIME      = 500;    // 0.5 s per blink phase
    localparam int DEF_DISPLAY_TIME    = 2000;   // 2 s per score phase
    localparam int DEF_DEBOUNCE_CYCLES = 20;     // 20 ms stable level

    // Segment patterns for the decoder
    localparam seg_t SEG_0     = 7'b0111111;
    localparam seg_t SEG_1     = 7'b0000110;
    localparam seg_t SEG_2     = 7'b1011011;
    localparam seg_t SEG_3     = 7'b1001111;
    localparam seg_t SEG_4     = 7'b1100110;
    localparam seg_t SEG_5     = 7'b1101101;
    localparam seg_t SEG_6     = 7'b1111101;
    localparam seg_t SEG_7     = 7'b0000111;
    localparam seg_t SEG_8     = 7'b1111111;
    localparam seg_t SEG_9     = 7'b1101111;
    localparam seg_t SEG_P     = 7'b1110011;   // Segments a b e f g
    localparam seg_t SEG_BLANK = 7'b0000000;

endpackage

/* source/button_debouncer.sv */
`timescale 1ns/100ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = score_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic clk_1khz,
    input  logic rst_i,
    input  logic btn_i,     // Raw asynchronous button
    output logic press_o    // One pulse per accepted press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             sync_ff1;
    logic             sync_ff2;
    logic             held_q;      // Last accepted level
    logic [CNT_W-1:0] stable_cnt;

    // Two flop synchronizer
    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            sync_ff1 <= 1'b0;
            sync_ff2 <= 1'b0;
        end else begin
            sync_ff1 <= btn_i;
            sync_ff2 <= sync_ff1;
        end
    end

    // A new level is accepted only after it stays put long enough
    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            held_q     <= 1'b0;
            stable_cnt <= '0;
            press_o    <= 1'b0;
        end else begin
            press_o <= 1'b0;
            if (sync_ff2 != held_q) begin
                if (stable_cnt == CNT_LAST) begin
                    held_q     <= sync_ff2;
                    stable_cnt <= '0;
                    press_o    <= sync_ff2;   // Pulse on the rising accept only
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;             // Bounce restarts the count
            end
        end
    end

    // One press must never look like two
    a_single_pulse: assert property (
        @(posedge clk_1khz) disable iff (rst_i)
        press_o |=> !press_o
    );

endmodule

/* source/score_counter.sv */
`timescale 1ns/100ps

module score_counter (
    input  logic              clk_1khz,
    input  logic              rst_i,
    input  logic              inc_i,      // Debounced press pulse
    input  logic              clear_i,    // Debounced clear pulse
    output score_pkg::digit_t tens_o,
    output score_pkg::digit_t ones_o
);

    import score_pkg::*;

    digit_t tens_q;
    digit_t ones_q;
    logic   at_max;

    assign at_max = (tens_q == DIGIT_MAX) && (ones_q == DIGIT_MAX);

    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            tens_q <= 4'd0;
            ones_q <= 4'd0;
        end else if (clear_i) begin       // Clear wins over increment
            tens_q <= 4'd0;
            ones_q <= 4'd0;
        end else if (inc_i && !at_max) begin
            if (ones_q == DIGIT_MAX) begin
                ones_q <= 4'd0;
                tens_q <= tens_q + 4'd1;  // BCD carry
            end else begin
                ones_q <= ones_q + 4'd1;
            end
        end
    end

    assign tens_o = tens_q;
    assign ones_o = ones_q;

    // Both digits remain valid BCD across any press sequence
    a_bcd_range: assert property (
        @(posedge clk_1khz) disable iff (rst_i)
        (tens_q <= DIGIT_MAX) && (ones_q <= DIGIT_MAX)
    );

endmodule

/* source/display_controller.sv */
`timescale 1ns/100ps

module display_controller #(
    parameter int BLINK_TIME   = score_pkg::DEF_BLINK_TIME,
    parameter int DISPLAY_TIME = score_pkg::DEF_DISPLAY_TIME
) (
    input  logic              clk_1khz,
    input  logic              rst_i,
    input  score_pkg::digit_t p1_tens_i,
    input  score_pkg::digit_t p1_ones_i,
    input  score_pkg::digit_t p2_tens_i,
    input  score_pkg::digit_t p2_ones_i,
    output score_pkg::digit_t tens_o,
    output score_pkg::digit_t ones_o
);

    import score_pkg::*;

    typedef enum logic [1:0] {
        P1_BLINK,
        P1_SHOW,
        P2_BLINK,
        P2_SHOW
    } phase_t;

    // The timer must hold the longer of the two phase lengths
    localparam int MAX_TIME = (DISPLAY_TIME > BLINK_TIME) ? DISPLAY_TIME : BLINK_TIME;
    localparam int TIMER_W  = $clog2(MAX_TIME + 1);

    localparam logic [TIMER_W-1:0] BLINK_LAST = TIMER_W'(BLINK_TIME - 1);
    localparam logic [TIMER_W-1:0] SHOW_LAST  = TIMER_W'(DISPLAY_TIME - 1);
    localparam logic [2:0]         BLINK_END  = 3'd4;   // Five sub-phases 0 to 4

    phase_t             state;
    logic [TIMER_W-1:0] timer;
    logic [2:0]         blink_cnt;
    logic               is_show;
    logic               phase_end;
    logic               blink_on;
    digit_t             next_tens;
    digit_t             next_ones;

    assign is_show   = (state == P1_SHOW) || (state == P2_SHOW);
    assign phase_end = (timer == (is_show ? SHOW_LAST : BLINK_LAST));
    assign blink_on  = ~blink_cnt[0];   // Even sub-phases show the label

    // Phase sequencing
    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            state     <= P1_BLINK;
            timer     <= '0;
            blink_cnt <= 3'd0;
        end else if (phase_end) begin
            timer <= '0;
            case (state)
                P1_BLINK: begin
                    if (blink_cnt == BLINK_END) begin
                        blink_cnt <= 3'd0;
                        state     <= P1_SHOW;
                    end else begin
                        blink_cnt <= blink_cnt + 3'd1;
                    end
                end
                P1_SHOW: state <= P2_BLINK;
                P2_BLINK: begin
                    if (blink_cnt == BLINK_END) begin
                        blink_cnt <= 3'd0;
                        state     <= P2_SHOW;
                    end else begin
                        blink_cnt <= blink_cnt + 3'd1;
                    end
                end
                P2_SHOW: state <= P1_BLINK;
                default: state <= P1_BLINK;
            endcase
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // Digit selection for the current phase
    always_comb begin
        next_tens = DIGIT_OFF;
        next_ones = DIGIT_OFF;
        case (state)
            P1_BLINK: begin
                if (blink_on) begin
                    next_tens = DIGIT_P;
                    next_ones = 4'd1;
                end
            end
            P1_SHOW: begin
                next_tens = p1_tens_i;   // Live score
                next_ones = p1_ones_i;
            end
            P2_BLINK: begin
                if (blink_on) begin
                    next_tens = DIGIT_P;
                    next_ones = 4'd2;
                end
            end
            P2_SHOW: begin
                next_tens = p2_tens_i;
                next_ones = p2_ones_i;
            end
            default: ;
        endcase
    end

    // Registered outputs, one cycle behind the phase
    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            tens_o <= DIGIT_P;           // P1 label right after reset
            ones_o <= 4'd1;
        end else begin
            tens_o <= next_tens;
            ones_o <= next_ones;
        end
    end

    // Blink sub-phase count stays within the five allowed values
    a_blink_range: assert property (
        @(posedge clk_1khz) disable iff (rst_i)
        blink_cnt <= BLINK_END
    );

endmodule

/* source/seven_seg_decoder.sv */
`timescale 1ns/100ps

module seven_seg_decoder (
    input  logic              clk_1khz,
    input  logic              rst_i,
    input  score_pkg::digit_t tens_i,
    input  score_pkg::digit_t ones_i,
    output score_pkg::seg_t   seg_tens_o,   // Active high, a in bit 0
    output score_pkg::seg_t   seg_ones_o
);

    import score_pkg::*;

    function automatic seg_t seg_lookup(input digit_t code);
        seg_t seg;
        case (code)
            4'd0:    seg = SEG_0;
            4'd1:    seg = SEG_1;
            4'd2:    seg = SEG_2;
            4'd3:    seg = SEG_3;
            4'd4:    seg = SEG_4;
            4'd5:    seg = SEG_5;
            4'd6:    seg = SEG_6;
            4'd7:    seg = SEG_7;
            4'd8:    seg = SEG_8;
            4'd9:    seg = SEG_9;
            DIGIT_P: seg = SEG_P;
            default: seg = SEG_BLANK;   // DIGIT_OFF and unused codes
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk_1khz) begin
        if (rst_i) begin
            seg_tens_o <= SEG_BLANK;
            seg_ones_o <= SEG_BLANK;
        end else begin
            seg_tens_o <= seg_lookup(tens_i);
            seg_ones_o <= seg_lookup(ones_i);
        end
    end

    // The controller only ever produces digits, blank or P
    a_code_range: assert property (
        @(posedge clk_1khz) disable iff (rst_i)
        (tens_i <= DIGIT_P) && (ones_i <= DIGIT_P)
    );

endmodule

/* source/scoreboard_top.sv */
`timescale 1ns/100ps

module scoreboard_top #(
    parameter int BLINK_TIME      = score_pkg::DEF_BLINK_TIME,
    parameter int DISPLAY_TIME    = score_pkg::DEF_DISPLAY_TIME,
    parameter int DEBOUNCE_CYCLES = score_pkg::DEF_DEBOUNCE_CYCLES
) (
    input  logic            clk_1khz,
    input  logic            rst_i,
    input  logic            p1_btn_i,
    input  logic            p2_btn_i,
    input  logic            clear_btn_i,
    output score_pkg::seg_t seg_tens_o,
    output score_pkg::seg_t seg_ones_o
);

    import score_pkg::*;

    logic   p1_press;
    logic   p2_press;
    logic   clear_press;
    digit_t p1_tens;
    digit_t p1_ones;
    digit_t p2_tens;
    digit_t p2_ones;
    digit_t disp_tens;   // Controller to decoder
    digit_t disp_ones;

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) p1_deb_i (
        .clk_1khz(clk_1khz), .rst_i(rst_i), .btn_i(p1_btn_i), .press_o(p1_press)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) p2_deb_i (
        .clk_1khz(clk_1khz), .rst_i(rst_i), .btn_i(p2_btn_i), .press_o(p2_press)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) clear_deb_i (
        .clk_1khz(clk_1khz), .rst_i(rst_i), .btn_i(clear_btn_i), .press_o(clear_press)
    );

    score_counter p1_score_i (
        .clk_1khz(clk_1khz), .rst_i(rst_i), .inc_i(p1_press), .clear_i(clear_press),
        .tens_o(p1_tens), .ones_o(p1_ones)
    );

    score_counter p2_score_i (
        .clk_1khz(clk_1khz), .rst_i(rst_i), .inc_i(p2_press), .clear_i(clear_press),
        .tens_o(p2_tens), .ones_o(p2_ones)
    );

    display_controller #(
        .BLINK_TIME  (BLINK_TIME),
        .DISPLAY_TIME(DISPLAY_TIME)
    ) ctrl_i (
        .clk_1khz (clk_1khz),
        .rst_i    (rst_i),
        .p1_tens_i(p1_tens),
        .p1_ones_i(p1_ones),
        .p2_tens_i(p2_tens),
        .p2_ones_i(p2_ones),
        .tens_o   (disp_tens),
        .ones_o   (disp_ones)
    );

    seven_seg_decoder dec_i (
        .clk_1khz  (clk_1khz),
        .rst_i     (rst_i),
        .tens_i    (disp_tens),
        .ones_i    (disp_ones),
        .seg_tens_o(seg_tens_o),
        .seg_ones_o(seg_ones_o)
    );

endmodule

/* testbench/tb_scoreboard.sv */
`timescale 1ns/100ps

module tb_scoreboard;

    import score_pkg::*;

    localparam int DEBOUNCE     = 3;
    localparam int PRESS_CYCLES = DEBOUNCE + 6;   // Hold and release time of a clean press
    localparam int SHORT_CYCLES = DEBOUNCE - 1;   // Too short to be accepted
    localparam int TIMEOUT      = 2000;
    localparam int STABLE_RUN   = 8;

    // Reference a to g patterns indexed by digit code
    localparam seg_t SEG_TABLE [0:11] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
        7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
        7'b1111111, 7'b1101111, 7'b0000000, 7'b1110011
    };

    logic   clk_1khz;
    logic   rst_i;
    logic   p1_btn_i;
    logic   p2_btn_i;
    logic   clear_btn_i;
    seg_t   seg_tens;
    seg_t   seg_ones;
    integer seed;
    int     steps_run;

    scoreboard_top #(
        .BLINK_TIME     (4),
        .DISPLAY_TIME   (16),
        .DEBOUNCE_CYCLES(DEBOUNCE)
    ) dut_i (
        .clk_1khz   (clk_1khz),
        .rst_i      (rst_i),
        .p1_btn_i   (p1_btn_i),
        .p2_btn_i   (p2_btn_i),
        .clear_btn_i(clear_btn_i),
        .seg_tens_o (seg_tens),
        .seg_ones_o (seg_ones)
    );

    initial begin
        clk_1khz = 1'b0;
        forever #5 clk_1khz = ~clk_1khz;
    end

    task automatic fail_stop(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%0s", why);
    endtask

    task automatic check_seg(input string what, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            $display("[FAIL] %0s expected %b actual %b", what, exp, act);
            fail_stop("segment pattern mismatch");
        end
    endtask

    task automatic check_digit(input string what, input digit_t exp, input digit_t act);
        if (act !== exp) begin
            $display("[FAIL] %0s expected %0d actual %0d", what, exp, act);
            fail_stop("score digit mismatch");
        end
    endtask

    // Unknown patterns come back as code 15
    function automatic digit_t decode_seg(input seg_t s);
        digit_t code;
        code = 4'hF;
        for (int i = 0; i < 12; i++) begin
            if (SEG_TABLE[i] == s) code = digit_t'(i);
        end
        return code;
    endfunction

    task automatic wait_label(input int player);
        int cnt;
        cnt = 0;
        @(negedge clk_1khz);
        while (!(seg_tens == SEG_TABLE[DIGIT_P] && seg_ones == SEG_TABLE[player])
               && cnt < TIMEOUT) begin
            @(negedge clk_1khz);
            cnt++;
        end
        if (cnt >= TIMEOUT) fail_stop("timeout waiting for the player label");
    endtask

    // Waits for a score pattern that holds still long enough
    task automatic wait_steady(output seg_t t, output seg_t o);
        int   cnt;
        int   run;
        seg_t pt;
        seg_t po;
        cnt = 0;
        run = 0;
        pt  = '0;
        po  = '0;
        while (run < STABLE_RUN && cnt < TIMEOUT) begin
            @(negedge clk_1khz);
            cnt++;
            if (seg_tens == SEG_TABLE[DIGIT_P] || (seg_tens == '0 && seg_ones == '0)) begin
                run = 0;                          // Label or blank phase
            end else if (run > 0 && seg_tens == pt && seg_ones == po) begin
                run++;
            end else begin
                run = 1;
                pt  = seg_tens;
                po  = seg_ones;
            end
        end
        if (run < STABLE_RUN) fail_stop("timeout waiting for a steady score");
        t = pt;
        o = po;
    endtask

    // Returns the current pattern and waits until it changes
    task automatic capture_run(output seg_t t, output seg_t o);
        int cnt;
        cnt = 0;
        t   = seg_tens;
        o   = seg_ones;
        while (seg_tens == t && seg_ones == o && cnt < TIMEOUT) begin
            @(negedge clk_1khz);
            cnt++;
        end
        if (cnt >= TIMEOUT) fail_stop("timeout waiting for the display to change");
    endtask

    // Label, blank, label, blank, label, score 00 for each player
    task automatic check_power_up();
        seg_t t;
        seg_t o;
        seg_t exp_t;
        seg_t exp_o;
        @(negedge clk_1khz);                      // Decoder still holds its reset value
        check_seg("power_up reset tens", SEG_TABLE[DIGIT_OFF], seg_tens);
        check_seg("power_up reset ones", SEG_TABLE[DIGIT_OFF], seg_ones);
        @(negedge clk_1khz);
        for (int player = 1; player <= 2; player++) begin
            for (int run = 0; run < 6; run++) begin
                if (run == 5) begin
                    exp_t = SEG_TABLE[0];
                    exp_o = SEG_TABLE[0];
                end else if (run % 2 == 0) begin
                    exp_t = SEG_TABLE[DIGIT_P];
                    exp_o = SEG_TABLE[player];
                end else begin
                    exp_t = SEG_TABLE[DIGIT_OFF];
                    exp_o = SEG_TABLE[DIGIT_OFF];
                end
                capture_run(t, o);
                check_seg($sformatf("power_up p%0d run %0d tens", player, run), exp_t, t);
                check_seg($sformatf("power_up p%0d run %0d ones", player, run), exp_o, o);
            end
        end
    endtask

    task automatic press_buttons(input logic p1, input logic p2, input logic clr,
                                 input int hold);
        int gap;
        gap = {$random(seed)} % 4;                // Uneven spacing between presses
        @(posedge clk_1khz);
        p1_btn_i    <= p1;
        p2_btn_i    <= p2;
        clear_btn_i <= clr;
        repeat (hold) @(posedge clk_1khz);
        p1_btn_i    <= 1'b0;
        p2_btn_i    <= 1'b0;
        clear_btn_i <= 1'b0;
        repeat (PRESS_CYCLES + gap) @(posedge clk_1khz);
    endtask

    task automatic check_score(input string name, input int player,
                               input digit_t exp_t, input digit_t exp_o);
        seg_t t;
        seg_t o;
        wait_label(player);
        wait_steady(t, o);
        check_digit($sformatf("%0s p%0d tens", name, player), exp_t, decode_seg(t));
        check_digit($sformatf("%0s p%0d ones", name, player), exp_o, decode_seg(o));
    endtask

    task automatic run_step(input string name, input int p1n, input int p2n, input int clr,
                            input int shorts, input int e1t, input int e1o,
                            input int e2t, input int e2o);
        for (int i = 0; i < p1n; i++) press_buttons(1'b1, 1'b0, 1'b0, PRESS_CYCLES);
        for (int i = 0; i < p2n; i++) press_buttons(1'b0, 1'b1, 1'b0, PRESS_CYCLES);
        for (int i = 0; i < shorts; i++) press_buttons(1'b1, 1'b1, 1'b0, SHORT_CYCLES);
        if (clr != 0) press_buttons(1'b1, 1'b1, 1'b1, PRESS_CYCLES);   // Clear beats both
        check_score(name, 1, digit_t'(e1t), digit_t'(e1o));
        check_score(name, 2, digit_t'(e2t), digit_t'(e2o));
        $display("step %0s done", name);
    endtask

    initial begin
        integer fd;
        int     n;
        int     cnt;
        string  line;
        string  name;
        int     p1n;
        int     p2n;
        int     clr;
        int     shorts;
        int     e1t;
        int     e1o;
        int     e2t;
        int     e2o;
        seed        = 32'h7c1e;
        steps_run   = 0;
        rst_i       = 1'b1;
        p1_btn_i    = 1'b0;
        p2_btn_i    = 1'b0;
        clear_btn_i = 1'b0;
        repeat (3) @(posedge clk_1khz);
        rst_i <= 1'b0;
        check_power_up();
        fd = $fopen("testbench/scoreboard_testdata.txt", "r");
        if (fd == 0) fail_stop("cannot open the test data file");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin   // Skip comments and empty lines
                cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d", name, p1n, p2n, clr,
                              shorts, e1t, e1o, e2t, e2o);
                if (cnt != 9) fail_stop("malformed line in the test data file");
                run_step(name, p1n, p2n, clr, shorts, e1t, e1o, e2t, e2o);
                steps_run++;
            end
        end
        $fclose(fd);
        if (steps_run == 0) begin
            fail_stop("the test data file holds no steps");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* testbench/scoreboard_testdata.txt */
# name p1_presses p2_presses clear short_presses p1_tens p1_ones p2_tens p2_ones
# Short presses pulse both player buttons below the debounce time
# Clear presses all three buttons together after the other presses of the step

first_presses     3   2 0 0 0 3 0 2
p1_to_nine        6   0 0 0 0 9 0 2

p1_carry          1   0 0 0 1 0 0 2
p2_carry          0   8 0 0 1 0 1 0
both_tens         5   3 0 0 1 5 1 3

short_glitch      0   0 0 3 1 5 1 3

clear_only        0   0 1 0 0 0 0 0
clear_with_press  2   1 1 0 0 0 0 0
restart           1   0 0 0 0 1 0 0

p1_to_99         98   0 0 0 9 9 0 0
p1_over_99        5   0 0 0 9 9 0 0
p2_to_99          0 100 0 0 9 9 9 9
p2_over_99        0   3 0 2 9 9 9 9

final_clear       0   0 1 0 0 0 0 0

/* files.f */
source/score_pkg.sv
source/button_debouncer.sv
source/score_counter.sv
source/display_controller.sv
source/seven_seg_decoder.sv
source/scoreboard_top.sv
testbench/tb_scoreboard.sv

/* run_sim.sh */
#!/bin/sh
# Builds the scoreboard testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_scoreboard \
    -f files.f \
    --Mdir obj_dir -o tb_scoreboard_sim

# The simulator exits non-zero on a fatal check, so keep its output for the search
sim_out=$(./obj_dir/tb_scoreboard_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
